// ==== verilog/dcache_miss_defs.svh ====
`ifndef DCACHE_MISS_DEFS_SVH
`define DCACHE_MISS_DEFS_SVH

// address split
`define DM_PADDR_BITS 32
`define DM_OFFSET_BITS 2
`define DM_BLOCK_BITS 28

// line layout
`define DM_WORD_BITS 32
`define DM_WORD_BYTES (`DM_WORD_BITS / 8)
`define DM_LINE_WORDS 4

// miss queue
`define DM_ENTRIES 4
`define DM_ENTRY_BITS 2

// waiting loads
`define DM_WAITERS 8
`define DM_LQ_BITS 4

`endif

// ==== verilog/dcache_miss_pkg.sv ====
`include "dcache_miss_defs.svh"

package dcache_miss_pkg;

    // one physical address, seen whole or split into block, word and byte
    typedef union packed {
        logic [`DM_PADDR_BITS-1:0] raw;
        struct packed {
            logic [`DM_BLOCK_BITS-1:0] block;
            logic [`DM_OFFSET_BITS-1:0] word;
            logic [`DM_PADDR_BITS-`DM_BLOCK_BITS-`DM_OFFSET_BITS-1:0] byte_sel;
        } f;
    } paddr_u;

endpackage

// ==== verilog/miss_enqueue.sv ====
`timescale 1ns/1ps
`include "dcache_miss_defs.svh"

module miss_enqueue (
    input  logic clk,
    input  logic rst,
    input  logic ren,
    input  dcache_miss_pkg::paddr_u raddr,
    input  logic [`DM_LQ_BITS-1:0] lq_idx,
    input  logic wen,
    input  dcache_miss_pkg::paddr_u waddr,
    input  logic [`DM_WORD_BITS-1:0] wdata,
    input  logic [`DM_WORD_BYTES-1:0] wmask,
    input  logic [`DM_ENTRIES-1:0] entry_valid,
    input  logic [`DM_ENTRIES-1:0][`DM_BLOCK_BITS-1:0] entry_block,
    input  logic tail_free,
    input  logic waiter_full,
    input  logic rlast_now,
    output logic rfull,
    output logic wfull,
    output logic alloc_en,
    output logic [`DM_BLOCK_BITS-1:0] alloc_block,
    output logic store_en,
    output logic [`DM_ENTRY_BITS-1:0] store_idx,
    output logic [`DM_OFFSET_BITS-1:0] store_off,
    output logic [`DM_WORD_BITS-1:0] store_data,
    output logic [`DM_WORD_BYTES-1:0] store_mask,
    output logic wait_en,
    output logic [`DM_ENTRY_BITS-1:0] wait_idx,
    output logic [`DM_OFFSET_BITS-1:0] wait_off,
    output logic [`DM_LQ_BITS-1:0] wait_lq
);
    logic [`DM_ENTRIES-1:0] rhit;
    logic [`DM_ENTRIES-1:0] whit;
    logic [`DM_ENTRY_BITS-1:0] rhit_idx;
    logic [`DM_ENTRY_BITS-1:0] whit_idx;
    logic [`DM_ENTRY_BITS-1:0] alloc_ptr;
    logic rw_same;
    logic load_ok;
    logic load_alloc;
    logic store_ok;
    logic store_alloc;

    // block match against every live entry
    always_comb begin
        rhit_idx = '0;
        whit_idx = '0;
        for (int i = 0; i < `DM_ENTRIES; i++) begin
            rhit[i] = entry_valid[i] && (entry_block[i] == raddr.f.block);
            whit[i] = entry_valid[i] && (entry_block[i] == waddr.f.block);
            if (rhit[i]) begin
                rhit_idx = rhit_idx | `DM_ENTRY_BITS'(i);
            end
            if (whit[i]) begin
                whit_idx = whit_idx | `DM_ENTRY_BITS'(i);
            end
        end
    end

    assign rw_same = ren && wen && (raddr.f.block == waddr.f.block);

    // only one entry can be allocated per cycle, and the load takes it first
    assign load_ok = ren && !waiter_full && (|rhit || tail_free);
    assign load_alloc = load_ok && !(|rhit);
    assign store_ok = wen && !rlast_now &&
                      (|whit || (rw_same && load_alloc) || (tail_free && !load_alloc));
    assign store_alloc = store_ok && !(|whit) && !(rw_same && load_alloc);

    assign alloc_en = load_alloc || store_alloc;
    assign alloc_block = load_alloc ? raddr.f.block : waddr.f.block;

    assign store_en = store_ok;
    assign store_idx = |whit ? whit_idx : alloc_ptr;
    assign store_off = waddr.f.word;
    assign store_data = wdata;
    assign store_mask = wmask;

    assign wait_en = load_ok;
    assign wait_idx = |rhit ? rhit_idx : alloc_ptr;
    assign wait_off = raddr.f.word;
    assign wait_lq = lq_idx;

    // alloc_ptr follows the queue tail
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rfull <= 1'b0;
            wfull <= 1'b0;
            alloc_ptr <= '0;
        end else begin
            rfull <= ren && !load_ok;
            wfull <= wen && !store_ok;
            if (alloc_en) begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end
        end
    end

    // the slot taken must be the free one at the queue tail
    a_alloc_room: assert property (@(posedge clk) disable iff (rst)
        alloc_en |-> tail_free && !entry_valid[alloc_ptr]);

endmodule

// ==== verilog/miss_queue.sv ====
`timescale 1ns/1ps
`include "dcache_miss_defs.svh"

module miss_queue (
    input  logic clk,
    input  logic rst,
    input  logic alloc_en,
    input  logic [`DM_BLOCK_BITS-1:0] alloc_block,
    input  logic store_en,
    input  logic [`DM_ENTRY_BITS-1:0] store_idx,
    input  logic [`DM_OFFSET_BITS-1:0] store_off,
    input  logic [`DM_WORD_BITS-1:0] store_data,
    input  logic [`DM_WORD_BYTES-1:0] store_mask,
    input  logic fetch_done,
    input  logic [`DM_LINE_WORDS-1:0][`DM_WORD_BITS-1:0] fetch_line,
    input  logic refill_ready,
    input  logic wake_busy,
    output logic [`DM_ENTRIES-1:0] entry_valid,
    output logic [`DM_ENTRIES-1:0][`DM_BLOCK_BITS-1:0] entry_block,
    output logic tail_free,
    output logic head_valid,
    output logic [`DM_BLOCK_BITS-1:0] head_block,
    output logic [`DM_LINE_WORDS-1:0][`DM_WORD_BITS-1:0] head_data,
    output logic [`DM_LINE_WORDS-1:0][`DM_WORD_BYTES-1:0] head_mask,
    output logic refill_en,
    output logic [`DM_PADDR_BITS-1:0] refill_addr,
    output logic [`DM_LINE_WORDS-1:0][`DM_WORD_BITS-1:0] refill_data,
    output logic refill_dirty,
    output logic refill_done,
    output logic [`DM_ENTRY_BITS-1:0] refill_idx
);
    import dcache_miss_pkg::*;

    logic [`DM_ENTRIES-1:0] valid;
    logic [`DM_ENTRIES-1:0] fetched;
    logic [`DM_ENTRY_BITS-1:0] head;
    logic [`DM_ENTRY_BITS-1:0] tail;
    logic [`DM_ENTRY_BITS:0] count;
    logic [`DM_ENTRIES-1:0][`DM_BLOCK_BITS-1:0] blk_q;
    logic [`DM_ENTRIES-1:0][`DM_LINE_WORDS-1:0][`DM_WORD_BITS-1:0] data_q;
    logic [`DM_ENTRIES-1:0][`DM_LINE_WORDS-1:0][`DM_WORD_BITS-1:0] data_nxt;
    logic [`DM_ENTRIES-1:0][`DM_LINE_WORDS-1:0][`DM_WORD_BYTES-1:0] mask_q;
    logic [`DM_ENTRIES-1:0][`DM_LINE_WORDS-1:0][`DM_WORD_BYTES-1:0] mask_nxt;
    logic refill_fire;
    paddr_u refill_pa;

    assign refill_fire = refill_en && refill_ready;
    assign tail_free = count != (`DM_ENTRY_BITS+1)'(`DM_ENTRIES);

    // head entry leaving this cycle takes no more hits
    always_comb begin
        entry_valid = valid;
        if (refill_fire) begin
            entry_valid[head] = 1'b0;
        end
    end

    assign entry_block = blk_q;
    // head still waiting for its line
    assign head_valid = valid[head] && !fetched[head];
    assign head_block = blk_q[head];
    assign head_data = data_q[head];
    assign head_mask = mask_q[head];

    always_comb begin
        refill_pa.raw = '0;
        refill_pa.f.block = blk_q[head];
    end

    assign refill_en = valid[head] && fetched[head] && !wake_busy;
    assign refill_addr = refill_pa.raw;
    assign refill_data = data_q[head];
    assign refill_dirty = |mask_q[head];
    assign refill_done = refill_fire;
    assign refill_idx = head;

    // fetched line first, then this cycle's store on top
    always_comb begin
        for (int i = 0; i < `DM_ENTRIES; i++) begin
            data_nxt[i] = (fetch_done && head == `DM_ENTRY_BITS'(i)) ? fetch_line : data_q[i];
            mask_nxt[i] = (alloc_en && tail == `DM_ENTRY_BITS'(i)) ? '0 : mask_q[i];
            if (store_en && store_idx == `DM_ENTRY_BITS'(i)) begin
                for (int b = 0; b < `DM_WORD_BYTES; b++) begin
                    if (store_mask[b]) begin
                        data_nxt[i][store_off][8*b +: 8] = store_data[8*b +: 8];
                    end
                end
                mask_nxt[i][store_off] = mask_nxt[i][store_off] | store_mask;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
            fetched <= '0;
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (alloc_en) begin
                valid[tail] <= 1'b1;
                fetched[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
            if (fetch_done) begin
                fetched[head] <= 1'b1;
            end
            if (refill_fire) begin
                valid[head] <= 1'b0;
                head <= head + 1'b1;
            end
            count <= count + {{`DM_ENTRY_BITS{1'b0}}, alloc_en}
                           - {{`DM_ENTRY_BITS{1'b0}}, refill_fire};
        end
    end

    always_ff @(posedge clk) begin
        data_q <= data_nxt;
        mask_q <= mask_nxt;
        if (alloc_en) begin
            blk_q[tail] <= alloc_block;
        end
    end

    a_refill_fetched: assert property (@(posedge clk) disable iff (rst)
        refill_fire |-> fetched[head] && !fetch_done);

    // wake_busy can only rise after a handshake, so a stalled offer stays up
    a_refill_hold: assert property (@(posedge clk) disable iff (rst)
        refill_en && !refill_ready |=> refill_en);

endmodule

// ==== verilog/line_fetch.sv ====
`timescale 1ns/1ps
`include "dcache_miss_defs.svh"

module line_fetch (
    input  logic clk,
    input  logic rst,
    input  logic head_valid,
    input  logic [`DM_BLOCK_BITS-1:0] head_block,
    input  logic [`DM_LINE_WORDS-1:0][`DM_WORD_BITS-1:0] head_data,
    input  logic [`DM_LINE_WORDS-1:0][`DM_WORD_BYTES-1:0] head_mask,
    input  logic mem_ack,
    input  logic mem_rvalid,
    input  logic [`DM_WORD_BITS-1:0] mem_rdata,
    input  logic mem_rlast,
    output logic mem_req,
    output logic [`DM_PADDR_BITS-1:0] mem_addr,
    output logic rlast_now,
    output logic fetch_done,
    output logic [`DM_LINE_WORDS-1:0][`DM_WORD_BITS-1:0] fetch_line
);
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_req = 2'd1;
    localparam logic [1:0] st_beats = 2'd2;
    localparam logic [1:0] st_done = 2'd3;
    localparam logic [`DM_OFFSET_BITS-1:0] last_beat = `DM_OFFSET_BITS'(`DM_LINE_WORDS - 1);

    logic [1:0] state;
    logic [`DM_OFFSET_BITS-1:0] beat_cnt;
    logic [`DM_LINE_WORDS-1:0][`DM_WORD_BITS-1:0] beat_buf;
    logic [`DM_LINE_WORDS-1:0][`DM_WORD_BITS-1:0] merged;

    assign mem_req = state == st_req;
    assign mem_addr = {head_block, {(`DM_PADDR_BITS - `DM_BLOCK_BITS){1'b0}}};
    assign rlast_now = mem_rvalid && mem_rlast;
    assign fetch_done = state == st_done;

    // current beat comes straight from the bus, stored bytes win
    always_comb begin
        for (int w = 0; w < `DM_LINE_WORDS; w++) begin
            merged[w] = (beat_cnt == `DM_OFFSET_BITS'(w)) ? mem_rdata : beat_buf[w];
            for (int b = 0; b < `DM_WORD_BYTES; b++) begin
                if (head_mask[w][b]) begin
                    merged[w][8*b +: 8] = head_data[w][8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            beat_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (head_valid) begin
                        state <= st_req;
                    end
                end
                st_req: begin
                    beat_cnt <= '0;
                    if (mem_ack) begin
                        state <= st_beats;
                    end
                end
                st_beats: begin
                    if (mem_rvalid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (mem_rlast) begin
                            state <= st_done;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_beats && mem_rvalid) begin
            beat_buf[beat_cnt] <= mem_rdata;
        end
        if (rlast_now) begin
            fetch_line <= merged;
        end
    end

    a_beat_in_burst: assert property (@(posedge clk) disable iff (rst)
        mem_rvalid |-> state == st_beats);

    a_last_beat: assert property (@(posedge clk) disable iff (rst)
        mem_rvalid |-> mem_rlast == (beat_cnt == last_beat));

endmodule

// ==== verilog/load_wakeup.sv ====
`timescale 1ns/1ps
`include "dcache_miss_defs.svh"

module load_wakeup (
    input  logic clk,
    input  logic rst,
    input  logic wait_en,
    input  logic [`DM_ENTRY_BITS-1:0] wait_idx,
    input  logic [`DM_OFFSET_BITS-1:0] wait_off,
    input  logic [`DM_LQ_BITS-1:0] wait_lq,
    input  logic refill_done,
    input  logic [`DM_ENTRY_BITS-1:0] refill_idx,
    input  logic [`DM_LINE_WORDS-1:0][`DM_WORD_BITS-1:0] refill_data,
    output logic waiter_full,
    output logic wake_busy,
    output logic lq_en,
    output logic [`DM_WORD_BITS-1:0] lq_data,
    output logic [`DM_LQ_BITS-1:0] lq_idx_o
);
    localparam int slot_bits = $clog2(`DM_WAITERS);

    logic [`DM_WAITERS-1:0] w_valid;
    logic [`DM_WAITERS-1:0] w_ready;
    logic [`DM_WAITERS-1:0][`DM_ENTRY_BITS-1:0] w_idx;
    logic [`DM_WAITERS-1:0][`DM_OFFSET_BITS-1:0] w_off;
    logic [`DM_WAITERS-1:0][`DM_LQ_BITS-1:0] w_lq;
    logic [`DM_LINE_WORDS-1:0][`DM_WORD_BITS-1:0] line_buf;
    logic [slot_bits-1:0] free_slot;
    logic [slot_bits-1:0] sel_slot;
    logic any_ready;

    // lowest free slot and lowest slot ready to return
    always_comb begin
        free_slot = '0;
        sel_slot = '0;
        for (int i = `DM_WAITERS - 1; i >= 0; i--) begin
            if (!w_valid[i]) begin
                free_slot = slot_bits'(i);
            end
            if (w_ready[i]) begin
                sel_slot = slot_bits'(i);
            end
        end
    end

    assign any_ready = |w_ready;
    assign waiter_full = &w_valid;
    assign wake_busy = any_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            w_valid <= '0;
            w_ready <= '0;
            lq_en <= 1'b0;
        end else begin
            if (wait_en) begin
                w_valid[free_slot] <= 1'b1;
                w_ready[free_slot] <= 1'b0;
            end
            // mark everyone waiting on the refilled entry
            if (refill_done) begin
                for (int i = 0; i < `DM_WAITERS; i++) begin
                    if (w_valid[i] && w_idx[i] == refill_idx) begin
                        w_ready[i] <= 1'b1;
                    end
                end
            end
            if (any_ready) begin
                w_valid[sel_slot] <= 1'b0;
                w_ready[sel_slot] <= 1'b0;
            end
            lq_en <= any_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (wait_en) begin
            w_idx[free_slot] <= wait_idx;
            w_off[free_slot] <= wait_off;
            w_lq[free_slot] <= wait_lq;
        end
        if (refill_done) begin
            line_buf <= refill_data;
        end
        if (any_ready) begin
            lq_data <= line_buf[w_off[sel_slot]];
            lq_idx_o <= w_lq[sel_slot];
        end
    end

    // the queue must not refill while the line buffer is still in use
    a_no_refill_busy: assert property (@(posedge clk) disable iff (rst)
        refill_done |-> !wake_busy);

endmodule

// ==== verilog/dcache_miss_unit.sv ====
`timescale 1ns/1ps
`include "dcache_miss_defs.svh"

module dcache_miss_unit (
    input  logic clk,
    input  logic rst,
    input  logic ren,
    input  dcache_miss_pkg::paddr_u raddr,
    input  logic [`DM_LQ_BITS-1:0] lq_idx,
    input  logic wen,
    input  dcache_miss_pkg::paddr_u waddr,
    input  logic [`DM_WORD_BITS-1:0] wdata,
    input  logic [`DM_WORD_BYTES-1:0] wmask,
    input  logic mem_ack,
    input  logic mem_rvalid,
    input  logic [`DM_WORD_BITS-1:0] mem_rdata,
    input  logic mem_rlast,
    input  logic refill_ready,
    output logic rfull,
    output logic wfull,
    output logic mem_req,
    output logic [`DM_PADDR_BITS-1:0] mem_addr,
    output logic refill_en,
    output logic [`DM_PADDR_BITS-1:0] refill_addr,
    output logic [`DM_LINE_WORDS-1:0][`DM_WORD_BITS-1:0] refill_data,
    output logic refill_dirty,
    output logic lq_en,
    output logic [`DM_WORD_BITS-1:0] lq_data,
    output logic [`DM_LQ_BITS-1:0] lq_idx_o
);
    // enqueue to queue
    logic [`DM_ENTRIES-1:0] entry_valid;
    logic [`DM_ENTRIES-1:0][`DM_BLOCK_BITS-1:0] entry_block;
    logic tail_free;
    logic alloc_en;
    logic [`DM_BLOCK_BITS-1:0] alloc_block;
    logic store_en;
    logic [`DM_ENTRY_BITS-1:0] store_idx;
    logic [`DM_OFFSET_BITS-1:0] store_off;
    logic [`DM_WORD_BITS-1:0] store_data;
    logic [`DM_WORD_BYTES-1:0] store_mask;

    // enqueue to wakeup
    logic waiter_full;
    logic wait_en;
    logic [`DM_ENTRY_BITS-1:0] wait_idx;
    logic [`DM_OFFSET_BITS-1:0] wait_off;
    logic [`DM_LQ_BITS-1:0] wait_lq;

    // queue and fetch
    logic rlast_now;
    logic head_valid;
    logic [`DM_BLOCK_BITS-1:0] head_block;
    logic [`DM_LINE_WORDS-1:0][`DM_WORD_BITS-1:0] head_data;
    logic [`DM_LINE_WORDS-1:0][`DM_WORD_BYTES-1:0] head_mask;
    logic fetch_done;
    logic [`DM_LINE_WORDS-1:0][`DM_WORD_BITS-1:0] fetch_line;

    // refill to wakeup
    logic refill_done;
    logic [`DM_ENTRY_BITS-1:0] refill_idx;
    logic wake_busy;

    miss_enqueue enqueue_i (.*);
    miss_queue queue_i (.*);
    line_fetch fetch_i (.*);
    load_wakeup wakeup_i (.*);

endmodule

// ==== bench/tb_dcache_miss_unit.sv ====
`timescale 1ns/1ps
`include "dcache_miss_defs.svh"

module tb_dcache_miss_unit;
    import dcache_miss_pkg::*;

    localparam int run_cycles = 3000;
    localparam int drain_limit = 2000;
    localparam int n_blocks = 6;
    localparam logic [`DM_BLOCK_BITS-1:0] block_base = 28'h0a5_c310;
    localparam int mem_idle = 0;
    localparam int mem_wait = 1;
    localparam int mem_acked = 2;
    localparam int mem_beats = 3;

    logic clk;
    logic rst;
    logic ren;
    paddr_u raddr;
    logic [`DM_LQ_BITS-1:0] lq_idx;
    logic wen;
    paddr_u waddr;
    logic [`DM_WORD_BITS-1:0] wdata;
    logic [`DM_WORD_BYTES-1:0] wmask;
    logic mem_ack;
    logic mem_rvalid;
    logic [`DM_WORD_BITS-1:0] mem_rdata;
    logic mem_rlast;
    logic refill_ready;
    logic rfull;
    logic wfull;
    logic mem_req;
    logic [`DM_PADDR_BITS-1:0] mem_addr;
    logic refill_en;
    logic [`DM_PADDR_BITS-1:0] refill_addr;
    logic [`DM_LINE_WORDS-1:0][`DM_WORD_BITS-1:0] refill_data;
    logic refill_dirty;
    logic lq_en;
    logic [`DM_WORD_BITS-1:0] lq_data;
    logic [`DM_LQ_BITS-1:0] lq_idx_o;

    logic [31:0] lcg_state;

    // live miss entries, oldest first
    logic [`DM_BLOCK_BITS-1:0] q_block [`DM_ENTRIES];
    logic [`DM_LINE_WORDS-1:0][`DM_WORD_BITS-1:0] q_line [`DM_ENTRIES];
    bit q_dirty [`DM_ENTRIES];
    bit q_fetched [`DM_ENTRIES];
    bit q_requested [`DM_ENTRIES];
    int q_id [`DM_ENTRIES];
    int q_cnt;
    int next_id;

    // waiter slots
    bit s_valid [`DM_WAITERS];
    bit s_ready [`DM_WAITERS];
    int s_id [`DM_WAITERS];
    logic [`DM_OFFSET_BITS-1:0] s_off [`DM_WAITERS];
    logic [`DM_LQ_BITS-1:0] s_lq [`DM_WAITERS];
    logic [`DM_WORD_BITS-1:0] s_data [`DM_WAITERS];

    bit exp_rfull;
    bit exp_wfull;
    bit exp_lq_en;
    logic [`DM_WORD_BITS-1:0] exp_lq_data;
    logic [`DM_LQ_BITS-1:0] exp_lq_idx;
    bit fetch_pend;
    int mstate;
    int ack_delay;
    int beat;
    logic [`DM_PADDR_BITS-1:0] maddr;
    int stall_left;
    bit drained;

    dcache_miss_unit dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int roll(input int n);
        return int'((next_rand() >> 16) % 32'(n));
    endfunction

    // memory contents, a hash of the full byte address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] h;
        h = addr * 32'h9e37_79b1;
        h = h ^ (h >> 15) ^ 32'h5bd1_e995;
        return h;
    endfunction

    function automatic logic [`DM_PADDR_BITS-1:0] block_addr(
        input logic [`DM_BLOCK_BITS-1:0] blk);
        return {blk, {(`DM_PADDR_BITS - `DM_BLOCK_BITS){1'b0}}};
    endfunction

    function automatic bit any_ready();
        bit r;
        r = 1'b0;
        for (int i = 0; i < `DM_WAITERS; i++) begin
            r = r | s_ready[i];
        end
        return r;
    endfunction

    function automatic int waiter_count();
        int n;
        n = 0;
        for (int i = 0; i < `DM_WAITERS; i++) begin
            n = n + int'(s_valid[i]);
        end
        return n;
    endfunction

    task automatic stop_on_failure();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic expect_value(input string what, input logic [127:0] got,
                                input logic [127:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s expected %0h got %0h", $time, what, exp, got);
            stop_on_failure();
        end
    endtask

    task automatic check_outputs();
        bit exp_refill;
        exp_refill = q_cnt > 0 && q_fetched[0] && !any_ready();
        expect_value("rfull", 128'(rfull), 128'(exp_rfull));
        expect_value("wfull", 128'(wfull), 128'(exp_wfull));
        expect_value("lq_en", 128'(lq_en), 128'(exp_lq_en));
        if (exp_lq_en) begin
            expect_value("lq_data", 128'(lq_data), 128'(exp_lq_data));
            expect_value("lq_idx_o", 128'(lq_idx_o), 128'(exp_lq_idx));
        end
        expect_value("refill_en", 128'(refill_en), 128'(exp_refill));
        if (exp_refill) begin
            expect_value("refill_addr", 128'(refill_addr), 128'(block_addr(q_block[0])));
            expect_value("refill_data", refill_data, q_line[0]);
            expect_value("refill_dirty", 128'(refill_dirty), 128'(q_dirty[0]));
        end
        if (mem_req) begin
            assert (q_cnt > 0 && !q_fetched[0] && mstate != mem_beats) else begin
                $display("MISMATCH at %0t: mem_req high with no head entry to fetch", $time);
                stop_on_failure();
            end
            expect_value("mem_addr", 128'(mem_addr), 128'(block_addr(q_block[0])));
            if (mstate == mem_idle) begin
                assert (!q_requested[0]) else begin
                    $display("MISMATCH at %0t: block requested twice for one entry", $time);
                    stop_on_failure();
                end
                q_requested[0] = 1'b1;
            end
        end else begin
            assert (mstate == mem_idle || mstate == mem_beats) else begin
                $display("MISMATCH at %0t: mem_req dropped before mem_ack", $time);
                stop_on_failure();
            end
        end
    endtask

    task automatic push_entry(input logic [`DM_BLOCK_BITS-1:0] blk);
        q_block[q_cnt] = blk;
        for (int w = 0; w < `DM_LINE_WORDS; w++) begin
            q_line[q_cnt][w] = mem_word(block_addr(blk) + 32'(w * `DM_WORD_BYTES));
        end
        q_dirty[q_cnt] = 1'b0;
        q_fetched[q_cnt] = 1'b0;
        q_requested[q_cnt] = 1'b0;
        q_id[q_cnt] = next_id;
        next_id++;
        q_cnt++;
    endtask

    task automatic pop_entry();
        for (int i = 0; i < q_cnt - 1; i++) begin
            q_block[i] = q_block[i+1];
            q_line[i] = q_line[i+1];
            q_dirty[i] = q_dirty[i+1];
            q_fetched[i] = q_fetched[i+1];
            q_requested[i] = q_requested[i+1];
            q_id[i] = q_id[i+1];
        end
        q_cnt--;
    endtask

    // one clock edge of the reference model, from the inputs of the ending cycle
    task automatic update_model();
        bit fire;
        bit rw_same;
        bit room;
        bit load_ok;
        bit load_alloc;
        bit store_ok;
        int first;
        int r_at;
        int w_at;
        int slot;
        int sel;
        int tgt;
        fire = q_cnt > 0 && q_fetched[0] && !any_ready() && refill_ready;
        first = fire ? 1 : 0;
        r_at = -1;
        w_at = -1;
        for (int i = first; i < q_cnt; i++) begin
            if (q_block[i] == raddr.f.block) r_at = i;
            if (q_block[i] == waddr.f.block) w_at = i;
        end
        room = q_cnt < `DM_ENTRIES;
        rw_same = ren && wen && raddr.f.block == waddr.f.block;
        load_ok = ren && waiter_count() < `DM_WAITERS && (r_at >= 0 || room);
        load_alloc = load_ok && r_at < 0;
        store_ok = wen && !(mem_rvalid && mem_rlast) &&
                   (w_at >= 0 || (rw_same && load_alloc) || (room && !load_alloc));
        exp_rfull = ren && !load_ok;
        exp_wfull = wen && !store_ok;
        slot = -1;
        sel = -1;
        for (int i = `DM_WAITERS - 1; i >= 0; i--) begin
            if (!s_valid[i]) slot = i;
            if (s_ready[i]) sel = i;
        end
        exp_lq_en = sel >= 0;
        if (sel >= 0) begin
            exp_lq_data = s_data[sel];
            exp_lq_idx = s_lq[sel];
            s_valid[sel] = 1'b0;
            s_ready[sel] = 1'b0;
        end
        if (load_alloc) begin
            push_entry(raddr.f.block);
        end else if (store_ok && w_at < 0) begin
            push_entry(waddr.f.block);
        end
        if (store_ok) begin
            tgt = w_at >= 0 ? w_at : q_cnt - 1;
            for (int b = 0; b < `DM_WORD_BYTES; b++) begin
                if (wmask[b]) q_line[tgt][waddr.f.word][8*b +: 8] = wdata[8*b +: 8];
            end
            q_dirty[tgt] = 1'b1;
        end
        if (load_ok) begin
            tgt = r_at >= 0 ? r_at : q_cnt - 1;
            s_valid[slot] = 1'b1;
            s_ready[slot] = 1'b0;
            s_id[slot] = q_id[tgt];
            s_off[slot] = raddr.f.word;
            s_lq[slot] = lq_idx;
        end
        if (fetch_pend) q_fetched[0] = 1'b1;
        fetch_pend = mem_rvalid && mem_rlast;
        if (fire) begin
            for (int i = 0; i < `DM_WAITERS; i++) begin
                if (s_valid[i] && !s_ready[i] && s_id[i] == q_id[0]) begin
                    s_ready[i] = 1'b1;
                    s_data[i] = q_line[0][s_off[i]];
                end
            end
            pop_entry();
        end
    endtask

    task automatic offer_beat();
        if (roll(3) == 0) begin
            mem_rvalid <= 1'b0;
            mem_rlast <= 1'b0;
        end else begin
            mem_rvalid <= 1'b1;
            mem_rdata <= mem_word(maddr + 32'(beat * `DM_WORD_BYTES));
            mem_rlast <= beat == `DM_LINE_WORDS - 1;
        end
    endtask

    task automatic respond_memory();
        case (mstate)
            mem_idle: begin
                if (mem_req) begin
                    maddr = mem_addr;
                    ack_delay = roll(4);
                    mstate = mem_wait;
                end
            end
            mem_wait: begin
                if (ack_delay == 0) begin
                    mem_ack <= 1'b1;
                    mstate = mem_acked;
                end else begin
                    ack_delay--;
                end
            end
            mem_acked: begin
                mem_ack <= 1'b0;
                beat = 0;
                mstate = mem_beats;
                offer_beat();
            end
            default: begin
                if (mem_rvalid) beat++;
                if (mem_rvalid && mem_rlast) begin
                    mem_rvalid <= 1'b0;
                    mem_rlast <= 1'b0;
                    mstate = mem_idle;
                end else begin
                    offer_beat();
                end
            end
        endcase
    endtask

    task automatic drive_requests(input bit active);
        paddr_u a;
        a.raw = '0;
        a.f.block = block_base + `DM_BLOCK_BITS'(roll(n_blocks) * 7);
        a.f.word = `DM_OFFSET_BITS'(roll(`DM_LINE_WORDS));
        ren <= active && roll(10) < 4;
        raddr <= a;
        lq_idx <= `DM_LQ_BITS'(roll(16));
        a.f.block = block_base + `DM_BLOCK_BITS'(roll(n_blocks) * 7);
        a.f.word = `DM_OFFSET_BITS'(roll(`DM_LINE_WORDS));
        wen <= active && roll(10) < 3;
        waddr <= a;
        wdata <= next_rand();
        wmask <= `DM_WORD_BYTES'(roll(15) + 1);
        // occasional long cache stall on top of short random ones
        if (stall_left > 0) begin
            stall_left--;
            refill_ready <= 1'b0;
        end else if (roll(64) == 0) begin
            stall_left = 8 + roll(12);
            refill_ready <= 1'b0;
        end else begin
            refill_ready <= roll(5) != 0;
        end
    endtask

    task automatic run_cycle(input bit active);
        @(posedge clk);
        check_outputs();
        update_model();
        respond_memory();
        drive_requests(active);
    endtask

    initial begin
        lcg_state = 32'h30c1_a28f;
        rst <= 1'b1;
        ren <= 1'b0;
        raddr <= '0;
        lq_idx <= '0;
        wen <= 1'b0;
        waddr <= '0;
        wdata <= '0;
        wmask <= '0;
        mem_ack <= 1'b0;
        mem_rvalid <= 1'b0;
        mem_rdata <= '0;
        mem_rlast <= 1'b0;
        refill_ready <= 1'b0;
        q_cnt = 0;
        next_id = 0;
        mstate = mem_idle;
        stall_left = 0;
        fetch_pend = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (int c = 0; c < run_cycles; c++) begin
            run_cycle(1'b1);
        end
        drained = 1'b0;
        for (int c = 0; c < drain_limit && !drained; c++) begin
            run_cycle(1'b0);
            drained = q_cnt == 0 && waiter_count() == 0 && !exp_lq_en && mstate == mem_idle;
        end
        if (drained) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("the miss unit did not drain within %0d cycles", drain_limit);
            stop_on_failure();
        end
    end

endmodule

// ==== dcache_miss_unit.f ====
+incdir+verilog
verilog/dcache_miss_pkg.sv
verilog/miss_enqueue.sv
verilog/miss_queue.sv
verilog/line_fetch.sv
verilog/load_wakeup.sv
verilog/dcache_miss_unit.sv
bench/tb_dcache_miss_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0 --timescale 1ns/1ps
TOP = tb_dcache_miss_unit
FILELIST = dcache_miss_unit.f
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
